/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tx_chan
RTL_TOP   ?= tx_chan_top
FILELIST  ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
+incdir+hdl
hdl/tx_chan_pkg.sv
hdl/tx_packet_buffer.sv
hdl/tx_chan_regs.sv
hdl/chan_fifo_reader.sv
hdl/tx_chan_top.sv
testbench/tx_chan_props.sv
testbench/tb_tx_chan.sv

/* hdl/chan_fifo_reader.sv */
`default_nettype none

`include "tx_chan_params.svh"

module chan_fifo_reader
(
    input  wire                       tx_clock,
    input  wire                       reset,
    input  wire                       tx_strobe,       // tx chain wants the next sample
    input  wire tx_chan_pkg::tstamp_t adc_time,        // current sample time
    input  wire tx_chan_pkg::fmt_t    samples_format,
    input  wire tx_chan_pkg::word_t   fifodata,        // word at the buffer read pointer
    input  wire                       pkt_waiting,
    output logic                      rdreq,           // acknowledge of fifodata
    output logic                      skip,            // drop rest of current packet
    output tx_chan_pkg::sample_t      tx_q,
    output tx_chan_pkg::sample_t      tx_i,
    output logic                      underrun,
    output logic                      tx_empty,        // tx chain sends zeros
    input  wire tx_chan_pkg::tstamp_t rssi,
    input  wire tx_chan_pkg::tstamp_t threshold,
    input  wire tx_chan_pkg::tstamp_t rssi_wait      // 0 waits forever
);

    tx_chan_pkg::reader_state_t reader_state;

    tx_chan_pkg::pkt_len_t payload_len;
    tx_chan_pkg::pkt_len_t read_len;     // samples sent so far
    tx_chan_pkg::tstamp_t  timestamp;
    tx_chan_pkg::tstamp_t  time_wait;    // cycles spent in WAIT
    tx_chan_pkg::tstamp_t  window_end;

    logic burst;       // inside a burst, next packet is expected
    logic trash;       // drop packets until the next start of burst
    logic rssi_flag;

    logic hdr_sob;
    logic hdr_eob;
    logic hdr_rssi;
    logic too_late;
    logic rssi_timeout;
    logic in_window;
    logic rssi_ok;
    logic more_samples;

    assign hdr_sob  = fifodata[`HDR_START_OF_BURST];
    assign hdr_eob  = fifodata[`HDR_END_OF_BURST];
    assign hdr_rssi = fifodata[`HDR_RSSI_FLAG];

    assign window_end   = adc_time + tx_chan_pkg::tstamp_t'(`TX_JITTER);
    assign too_late     = (timestamp < adc_time);
    assign rssi_timeout = rssi_flag && (rssi_wait != '0) && (time_wait >= rssi_wait);
    // all ones means send as soon as possible
    assign in_window    = (timestamp > adc_time && timestamp <= window_end) ||
                          (timestamp == '1);
    assign rssi_ok      = !rssi_flag || (rssi <= threshold);
    assign more_samples = (read_len != payload_len);

    always_ff @(posedge tx_clock)
    begin
        if (reset)
        begin
            reader_state <= tx_chan_pkg::IDLE;
            rdreq        <= 1'b0;
            skip         <= 1'b0;
            underrun     <= 1'b0;
            tx_empty     <= 1'b1;
            tx_i         <= '0;
            tx_q         <= '0;
            burst        <= 1'b0;
            trash        <= 1'b0;
            rssi_flag    <= 1'b0;
            time_wait    <= '0;
        end
        else
        begin
            // a strobe with nothing to hand over sends zeros
            if (tx_strobe && !(reader_state == tx_chan_pkg::WAITSTROBE && more_samples))
                tx_empty <= 1'b1;

            case (reader_state)
                tx_chan_pkg::IDLE:
                begin
                    skip      <= 1'b0;
                    time_wait <= '0;
                    if (pkt_waiting)
                    begin
                        reader_state <= tx_chan_pkg::HEADER;
                        rdreq        <= 1'b1;
                        underrun     <= 1'b0;
                    end
                    else if (burst)
                    begin
                        underrun <= 1'b1;  // burst open but host fell behind
                    end
                end

                tx_chan_pkg::HEADER:
                begin
                    rssi_flag <= hdr_rssi && hdr_sob;
                    if (hdr_sob || hdr_eob)
                        burst <= hdr_sob && !hdr_eob;

                    if (trash && !hdr_sob)
                    begin
                        // rest of a dropped burst
                        reader_state <= tx_chan_pkg::IDLE;
                        skip         <= 1'b1;
                        rdreq        <= 1'b0;
                    end
                    else
                    begin
                        reader_state <= tx_chan_pkg::TIMESTAMP;
                        payload_len  <= fifodata[`HDR_PAYLOAD_MSB:`HDR_PAYLOAD_LSB];
                        read_len     <= '0;
                        rdreq        <= 1'b1;
                    end
                end

                tx_chan_pkg::TIMESTAMP:
                begin
                    reader_state <= tx_chan_pkg::WAIT;
                    timestamp    <= fifodata;
                    rdreq        <= 1'b0;
                end

                tx_chan_pkg::WAIT:
                begin
                    time_wait <= time_wait + 1'b1;
                    if (too_late || rssi_timeout)
                    begin
                        reader_state <= tx_chan_pkg::IDLE;
                        trash        <= 1'b1;
                        skip         <= 1'b1;
                    end
                    else if (in_window && rssi_ok)
                    begin
                        reader_state <= tx_chan_pkg::WAITSTROBE;
                        trash        <= 1'b0;
                    end
                end

                tx_chan_pkg::WAITSTROBE:
                begin
                    if (!more_samples)
                    begin
                        reader_state <= tx_chan_pkg::IDLE;  // packet done, move to the next
                        skip         <= 1'b1;
                    end
                    else if (tx_strobe)
                    begin
                        reader_state <= tx_chan_pkg::SEND;
                        rdreq        <= 1'b1;
                    end
                end

                tx_chan_pkg::SEND:
                begin
                    reader_state <= tx_chan_pkg::WAITSTROBE;
                    read_len     <= read_len + 1'b1;
                    tx_empty     <= 1'b0;
                    rdreq        <= 1'b0;
                    {tx_q, tx_i} <= fifodata;  // every format code unpacks as QI16
                end

                default:
                begin
                    reader_state <= tx_chan_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/tx_chan_params.svh */
`ifndef TX_CHAN_PARAMS_SVH
`define TX_CHAN_PARAMS_SVH

// header word fields
`define HDR_PAYLOAD_MSB     8   // payload word count, msb
`define HDR_PAYLOAD_LSB     2
`define HDR_RSSI_FLAG       26  // hold until rssi drops, valid with start of burst
`define HDR_END_OF_BURST    27
`define HDR_START_OF_BURST  28

// send window ahead of adc_time, in sample times
`define TX_JITTER           5

// 16 bit interleaved complex samples
`define FMT_QI16            4'd0

// packet buffer sizing
`define BUF_ADDR_BITS       8   // 256 words
`define PKT_SLOTS_BITS      3   // 8 queued packets

// register map
`define REG_THRESHOLD       2'd0
`define REG_RSSI_WAIT       2'd1
`define REG_FORMAT          2'd2
`define REG_STATUS          2'd3

`endif

/* hdl/tx_chan_pkg.sv */
`default_nettype none

package tx_chan_pkg;

    // one buffer word, header, timestamp or packed I/Q sample
    typedef logic [31:0] word_t;

    // single I or Q component
    typedef logic [15:0] sample_t;

    // sample time, also used for rssi and its wait limit
    typedef logic [31:0] tstamp_t;

    typedef logic [6:0] pkt_len_t;   // payload words per packet

    typedef logic [3:0] fmt_t;       // sample format code

    typedef logic [1:0] cfg_addr_t;  // register address

    // channel reader states
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        TIMESTAMP,
        WAIT,        // hold until the timestamp comes due
        WAITSTROBE,  // wait for the tx chain to ask for a sample
        SEND
    } reader_state_t;

endpackage

`default_nettype wire

/* hdl/tx_chan_regs.sv */
`default_nettype none

`include "tx_chan_params.svh"

module tx_chan_regs
(
    input  wire                        tx_clock,
    input  wire                        reset,
    input  wire                        cfg_write,
    input  wire                        cfg_read,
    input  wire tx_chan_pkg::cfg_addr_t cfg_addr,
    input  wire tx_chan_pkg::word_t    cfg_wdata,
    output tx_chan_pkg::word_t         cfg_rdata,
    input  wire                        underrun,
    output tx_chan_pkg::tstamp_t       threshold,
    output tx_chan_pkg::tstamp_t       rssi_wait,
    output tx_chan_pkg::fmt_t          samples_format
);

    logic underrun_d;       // previous underrun, for edge detect
    logic underrun_sticky;
    logic status_clear;

    assign status_clear = cfg_write && (cfg_addr == `REG_STATUS);

    always_ff @(posedge tx_clock)
    begin
        if (reset)
        begin
            threshold       <= '0;
            rssi_wait       <= '0;
            samples_format  <= '0;
            underrun_d      <= 1'b0;
            underrun_sticky <= 1'b0;
            cfg_rdata       <= '0;
        end
        else
        begin
            underrun_d <= underrun;

            if (cfg_write)
            begin
                case (cfg_addr)
                    `REG_THRESHOLD: threshold      <= cfg_wdata;
                    `REG_RSSI_WAIT: rssi_wait      <= cfg_wdata;
                    `REG_FORMAT:    samples_format <= cfg_wdata[$bits(tx_chan_pkg::fmt_t)-1:0];
                    default:        ;  // status write only clears the sticky bit
                endcase
            end

            // a new underrun wins over a clear in the same cycle
            if (underrun && !underrun_d)
                underrun_sticky <= 1'b1;
            else if (status_clear)
                underrun_sticky <= 1'b0;

            if (cfg_read)
            begin
                case (cfg_addr)
                    `REG_THRESHOLD: cfg_rdata <= threshold;
                    `REG_RSSI_WAIT: cfg_rdata <= rssi_wait;
                    `REG_FORMAT:    cfg_rdata <= tx_chan_pkg::word_t'(samples_format);
                    `REG_STATUS:    cfg_rdata <= tx_chan_pkg::word_t'(underrun_sticky);
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/tx_chan_top.sv */
`default_nettype none

module tx_chan_top
(
    input  wire                        tx_clock,
    input  wire                        reset,
    input  wire                        wr_strobe,
    input  wire tx_chan_pkg::word_t    wr_data,
    input  wire                        wr_end,
    output wire                        buf_full,
    input  wire                        cfg_write,
    input  wire                        cfg_read,
    input  wire tx_chan_pkg::cfg_addr_t cfg_addr,
    input  wire tx_chan_pkg::word_t    cfg_wdata,
    output tx_chan_pkg::word_t         cfg_rdata,
    input  wire tx_chan_pkg::tstamp_t  adc_time,
    input  wire tx_chan_pkg::tstamp_t  rssi,
    input  wire                        tx_strobe,
    output tx_chan_pkg::sample_t       tx_i,
    output tx_chan_pkg::sample_t       tx_q,
    output wire                        tx_empty,
    output wire                        underrun
);

    tx_chan_pkg::word_t   fifodata;
    wire                  pkt_waiting;
    wire                  rdreq;
    wire                  skip;
    tx_chan_pkg::tstamp_t threshold;
    tx_chan_pkg::tstamp_t rssi_wait;
    tx_chan_pkg::fmt_t    samples_format;

    tx_packet_buffer buf0
    (
        .tx_clock    (tx_clock),
        .reset       (reset),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .wr_end      (wr_end),
        .rdreq       (rdreq),
        .skip        (skip),
        .fifodata    (fifodata),
        .pkt_waiting (pkt_waiting),
        .buf_full    (buf_full)
    );

    tx_chan_regs regs0
    (
        .tx_clock       (tx_clock),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_read       (cfg_read),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .underrun       (underrun),
        .threshold      (threshold),
        .rssi_wait      (rssi_wait),
        .samples_format (samples_format)
    );

    chan_fifo_reader reader0
    (
        .tx_clock       (tx_clock),
        .reset          (reset),
        .tx_strobe      (tx_strobe),
        .adc_time       (adc_time),
        .samples_format (samples_format),
        .fifodata       (fifodata),
        .pkt_waiting    (pkt_waiting),
        .rdreq          (rdreq),
        .skip           (skip),
        .tx_q           (tx_q),
        .tx_i           (tx_i),
        .underrun       (underrun),
        .tx_empty       (tx_empty),
        .rssi           (rssi),
        .threshold      (threshold),
        .rssi_wait      (rssi_wait)
    );

endmodule

`default_nettype wire

/* hdl/tx_packet_buffer.sv */
`default_nettype none

`include "tx_chan_params.svh"

module tx_packet_buffer
(
    input  wire                 tx_clock,
    input  wire                 reset,
    input  wire                 wr_strobe,
    input  wire tx_chan_pkg::word_t wr_data,
    input  wire                 wr_end,
    input  wire                 rdreq,
    input  wire                 skip,
    output tx_chan_pkg::word_t  fifodata,
    output logic                pkt_waiting,
    output logic                buf_full
);

    localparam int DEPTH = 1 << `BUF_ADDR_BITS;
    localparam int SLOTS = 1 << `PKT_SLOTS_BITS;

    tx_chan_pkg::word_t mem [DEPTH];

    // pointers carry one extra bit so full and empty differ
    logic [`BUF_ADDR_BITS:0] wr_ptr;
    logic [`BUF_ADDR_BITS:0] rd_ptr;
    logic [`BUF_ADDR_BITS:0] used;

    // start address of the packet that follows each complete one
    logic [`BUF_ADDR_BITS:0] next_start [SLOTS];
    logic [`PKT_SLOTS_BITS-1:0] q_head;
    logic [`PKT_SLOTS_BITS-1:0] q_tail;
    logic [`PKT_SLOTS_BITS:0] pkt_count;

    logic words_full;
    logic slots_full;
    logic empty;
    logic wr_ok;
    logic push;
    logic pop;

    assign used       = wr_ptr - rd_ptr;
    assign empty      = (used == '0);
    assign words_full = used[`BUF_ADDR_BITS];        // used == DEPTH
    assign slots_full = pkt_count[`PKT_SLOTS_BITS];  // pkt_count == SLOTS
    assign buf_full   = words_full || slots_full;

    assign wr_ok = wr_strobe && !buf_full;  // writes while full are lost
    assign push  = wr_ok && wr_end;
    assign pop   = skip && (pkt_count != '0);

    // the packet being skipped no longer counts as waiting
    assign pkt_waiting = (pkt_count != '0) &&
                         !(skip && pkt_count == (`PKT_SLOTS_BITS + 1)'(1));

    // show-ahead read
    assign fifodata = mem[rd_ptr[`BUF_ADDR_BITS-1:0]];

    always_ff @(posedge tx_clock)
    begin
        if (wr_ok)
            mem[wr_ptr[`BUF_ADDR_BITS-1:0]] <= wr_data;
        if (push)
            next_start[q_tail] <= wr_ptr + 1'b1;
    end

    always_ff @(posedge tx_clock)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_head    <= '0;
            q_tail    <= '0;
            pkt_count <= '0;
        end
        else
        begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;

            if (push)
                q_tail <= q_tail + 1'b1;

            // skip jumps over whatever is left of the current packet
            if (pop)
            begin
                rd_ptr <= next_start[q_head];
                q_head <= q_head + 1'b1;
            end
            else if (rdreq && !empty)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   pkt_count <= pkt_count + 1'b1;
                2'b01:   pkt_count <= pkt_count - 1'b1;
                default: pkt_count <= pkt_count;  // none, or one in and one out
            endcase
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_tx_chan.sv */
`default_nettype none

`include "tx_chan_params.svh"

module tb_tx_chan;
    timeunit 1ns;
    timeprecision 1ns;

    typedef struct {
        string name;
        int    sob;
        int    eob;
        int    rssi_flag;
        int    words;
        int    asap;
        int    offset;
        int    rssi;
        int    threshold;
        int    rssi_wait;
        int    send;
        int    underrun;
        int    chain;
    } case_t;

    logic tx_clock = 1'b0;
    logic reset;
    logic wr_strobe;
    tx_chan_pkg::word_t wr_data;
    logic wr_end;
    logic buf_full;
    logic cfg_write;
    logic cfg_read;
    tx_chan_pkg::cfg_addr_t cfg_addr;
    tx_chan_pkg::word_t cfg_wdata;
    tx_chan_pkg::word_t cfg_rdata;
    tx_chan_pkg::tstamp_t adc_time = 32'd1000;
    tx_chan_pkg::tstamp_t rssi;
    logic tx_strobe = 1'b0;
    tx_chan_pkg::sample_t tx_i;
    tx_chan_pkg::sample_t tx_q;
    logic tx_empty;
    logic underrun;

    case_t cases[$];
    tx_chan_pkg::word_t exp_words[$];  // payload still to come out, in order
    int check_errors = 0;
    int skip_count;
    int pkts_written = 0;
    int watchdog_cycles = 0;
    logic [31:0] cyc;
    logic strobe_d1;
    logic strobe_d2;

    tx_chan_top dut0
    (
        .tx_clock  (tx_clock),
        .reset     (reset),
        .wr_strobe (wr_strobe),
        .wr_data   (wr_data),
        .wr_end    (wr_end),
        .buf_full  (buf_full),
        .cfg_write (cfg_write),
        .cfg_read  (cfg_read),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .adc_time  (adc_time),
        .rssi      (rssi),
        .tx_strobe (tx_strobe),
        .tx_i      (tx_i),
        .tx_q      (tx_q),
        .tx_empty  (tx_empty),
        .underrun  (underrun)
    );

    always #50 tx_clock = ~tx_clock;

    // sample time ticks every 8 cycles, the tx chain asks every 4
    always @(posedge tx_clock)
    begin
        if (reset)
        begin
            cyc       <= '0;
            adc_time  <= 32'd1000;
            tx_strobe <= 1'b0;
        end
        else
        begin
            cyc <= cyc + 1;
            if (cyc[2:0] == 3'd7)
                adc_time <= adc_time + 1;
            tx_strobe <= (cyc[1:0] == 2'd3);
        end
    end

    always @(posedge tx_clock)
    begin
        strobe_d1 <= tx_strobe && !reset;
        strobe_d2 <= strobe_d1;
        if (reset)
            skip_count <= 0;
        else if (dut0.skip)
            skip_count <= skip_count + 1;  // one skip closes every packet
    end

    // new sample is out two edges after the strobe was seen
    always @(negedge tx_clock)
    begin
        if (strobe_d2 && !tx_empty)
        begin
            if (exp_words.size() == 0)
            begin
                $display("CHECK FAILED at %0t: sample %h out with no packet pending",
                         $time, {tx_q, tx_i});
                check_errors++;
            end
            else
            begin
                if ({tx_q, tx_i} !== exp_words[0])
                begin
                    $display("CHECK FAILED at %0t: sample q/i %h expected %h",
                             $time, {tx_q, tx_i}, exp_words[0]);
                    check_errors++;
                end
                void'(exp_words.pop_front());
            end
        end
    end

    initial
    begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge tx_clock);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    task automatic load_cases();
        int fd;
        int n;
        string line;
        string offs;
        string outcome;
        case_t c;
        fd = $fopen("testbench/tx_chan_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the case file testbench/tx_chan_cases.txt");
            $display("sim failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %d %d %d %d %s %d %d %d %s %d %d", c.name, c.sob,
                            c.eob, c.rssi_flag, c.words, offs, c.rssi, c.threshold,
                            c.rssi_wait, outcome, c.underrun, c.chain);
                if (n == 12)  // comment and blank lines fall out here
                begin
                    c.asap   = (offs == "asap");
                    c.offset = 0;
                    if (!c.asap)
                        void'($sscanf(offs, "%d", c.offset));
                    c.send = (outcome == "send");
                    cases.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_value(string what, tx_chan_pkg::word_t got, tx_chan_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s read %h expected %h", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic write_reg(tx_chan_pkg::cfg_addr_t a, tx_chan_pkg::word_t d);
        @(posedge tx_clock);
        cfg_write <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge tx_clock);
        cfg_write <= 1'b0;
    endtask

    task automatic read_reg_check(string what, tx_chan_pkg::cfg_addr_t a,
                                  tx_chan_pkg::word_t exp);
        @(posedge tx_clock);
        cfg_read <= 1'b1;
        cfg_addr <= a;
        @(posedge tx_clock);
        cfg_read <= 1'b0;
        @(negedge tx_clock);  // readback registered on the edge just past
        check_value(what, cfg_rdata, exp);
    endtask

    task automatic write_packet(case_t c);
        tx_chan_pkg::word_t hdr;
        tx_chan_pkg::word_t ts;
        tx_chan_pkg::word_t w;
        // a few short packets never come near the buffer size or slot count
        if (buf_full)
        begin
            $display("CHECK FAILED at %0t: buf_full high before packet %s", $time, c.name);
            check_errors++;
        end
        hdr = '0;
        hdr[`HDR_START_OF_BURST] = c.sob[0];
        hdr[`HDR_END_OF_BURST]   = c.eob[0];
        hdr[`HDR_RSSI_FLAG]      = c.rssi_flag[0];
        hdr[`HDR_PAYLOAD_MSB:`HDR_PAYLOAD_LSB] = c.words[6:0];
        @(posedge tx_clock);
        ts = c.asap ? '1 : adc_time + c.offset;
        rssi      <= c.rssi;  // level the reader sees once it waits on this packet
        wr_strobe <= 1'b1;
        wr_data   <= hdr;
        wr_end    <= 1'b0;
        @(posedge tx_clock);
        wr_data <= ts;
        wr_end  <= (c.words == 0);
        for (int k = 0; k < c.words; k++)
        begin
            @(posedge tx_clock);
            w = $urandom;
            wr_data <= w;
            wr_end  <= (k == c.words - 1);
            if (c.send)
                exp_words.push_back(w);
        end
        @(posedge tx_clock);
        wr_strobe <= 1'b0;
        wr_end    <= 1'b0;
        pkts_written++;
    endtask

    task automatic setup_and_write(case_t c);
        write_reg(`REG_THRESHOLD, c.threshold);
        write_reg(`REG_RSSI_WAIT, c.rssi_wait);
        read_reg_check("threshold", `REG_THRESHOLD, c.threshold);
        read_reg_check("rssi_wait", `REG_RSSI_WAIT, c.rssi_wait);
        write_packet(c);
    endtask

    task automatic wait_packets_done();
        int n;
        n = 0;
        while (!(skip_count >= pkts_written && exp_words.size() == 0 && tx_empty) && n < 400)
        begin
            @(posedge tx_clock);
            n++;
        end
        if (n >= 400)
        begin
            $display("timed out at %0t waiting for the packets to finish", $time);
            check_errors++;
        end
    endtask

    task automatic check_underrun(int expected);
        int n;
        n = 0;
        if (expected != 0)
        begin
            while (!underrun && n < 400)
            begin
                @(posedge tx_clock);
                n++;
            end
            if (n >= 400)
            begin
                $display("underrun never rose by %0t", $time);
                check_errors++;
            end
            repeat (2) @(posedge tx_clock);  // sticky bit lands on the next edge
        end
        read_reg_check("status", `REG_STATUS, expected);
        if (expected != 0)
        begin
            write_reg(`REG_STATUS, 32'd1);
            read_reg_check("status after clear", `REG_STATUS, 32'd0);
        end
    endtask

    initial
    begin
        int i;
        int first;
        int err0;
        int ur;
        int passed;
        int failed;
        passed    = 0;
        failed    = 0;
        reset     = 1'b1;
        wr_strobe = 1'b0;
        wr_data   = '0;
        wr_end    = 1'b0;
        cfg_write = 1'b0;
        cfg_read  = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rssi      = '0;
        void'($urandom(32'hc45ac943));
        load_cases();
        watchdog_cycles = 400 * cases.size() + 1000;
        repeat (5) @(posedge tx_clock);
        reset <= 1'b0;
        @(posedge tx_clock);

        // a code other than the reset value first, so the write shows
        write_reg(`REG_FORMAT, 32'ha);
        read_reg_check("format", `REG_FORMAT, 32'ha);
        write_reg(`REG_FORMAT, `FMT_QI16);
        read_reg_check("format", `REG_FORMAT, `FMT_QI16);

        i = 0;
        while (i < cases.size())
        begin
            first = i;
            err0  = check_errors;
            setup_and_write(cases[i]);
            while (cases[i].chain != 0 && i + 1 < cases.size())
            begin
                i++;
                setup_and_write(cases[i]);  // back to back, reader still busy
            end
            wait_packets_done();
            ur = 0;
            for (int k = first; k <= i; k++)
                ur = ur | cases[k].underrun;
            check_underrun(ur);
            for (int k = first; k <= i; k++)
            begin
                if (check_errors == err0)
                begin
                    $display("test %s ok", cases[k].name);
                    passed++;
                end
                else
                begin
                    $display("test %s FAILED", cases[k].name);
                    failed++;
                end
            end
            i++;
        end

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 passed, failed, check_errors);
        if (check_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tx_chan_cases.txt */
# name sob eob rssi_flag payload_words ts_offset(or asap) rssi threshold rssi_wait
#   expect(send/drop) underrun(0/1) chain(1 = next packet written without waiting)
in_window    1 1 0 4  3    0   0  0  send 0 0
asap_ts      1 1 0 6  asap 0   0  0  send 0 0
late_ts      1 1 0 3  -3   0   0  0  drop 0 0
trash_cont   0 1 0 3  3    0   0  0  drop 0 0
after_trash  1 1 0 2  3    0   0  0  send 0 0
rssi_high    1 1 1 4  asap 200 50 24 drop 0 0
rssi_low     1 1 1 4  asap 40  50 24 send 0 0
burst_open   1 0 0 3  3    0   0  0  send 1 0
back2back_a  1 1 0 5  3    0   0  0  send 0 1
back2back_b  1 1 0 5  asap 0   0  0  send 0 0
long_pkt     1 1 0 16 asap 0   0  0  send 0 0

/* testbench/tx_chan_props.sv */
`default_nettype none

module tx_chan_props
(
    input wire                             tx_clock,
    input wire                             reset,
    input wire                             skip,
    input wire                             rdreq,
    input wire                             tx_empty,
    input wire tx_chan_pkg::reader_state_t reader_state
);
    timeunit 1ns;
    timeprecision 1ns;

    // skip moves the buffer by a whole packet, so it must be a single pulse
    skip_one_cycle: assert property (@(posedge tx_clock) disable iff (reset)
        skip |=> !skip)
        else $error("skip held for more than one cycle");

    no_read_in_wait: assert property (@(posedge tx_clock) disable iff (reset)
        (reader_state == tx_chan_pkg::WAIT) |-> !rdreq)
        else $error("rdreq high while the reader waits on the timestamp");

    // a new sample only comes out of SEND
    empty_falls_after_send: assert property (@(posedge tx_clock) disable iff (reset)
        $fell(tx_empty) |-> ($past(reader_state) == tx_chan_pkg::SEND))
        else $error("tx_empty fell outside of SEND");

endmodule

bind chan_fifo_reader tx_chan_props props0
(
    .tx_clock     (tx_clock),
    .reset        (reset),
    .skip         (skip),
    .rdreq        (rdreq),
    .tx_empty     (tx_empty),
    .reader_state (reader_state)
);

`default_nettype wire
